/* afifo_bank.f */
+incdir+.
afifo_pkg.sv
afifo_mem.sv
afifo_cmp.sv
afifo_wptr_full.sv
afifo_rptr_empty.sv
afifo_lane.sv
lane_dispatch.sv
lane_merge.sv
afifo_bank.sv
tb_afifo_bank.sv

/* afifo_bank.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module afifo_bank
    import afifo_pkg::*;
(
    input  wire logic         wclk,
    input  wire logic         rclk,
    input  wire logic         aempty_n,
    input  wire logic         in_valid,
    input  wire tagged_word_t in_word,
    output logic              in_ready,
    output logic              out_valid,
    output tagged_word_t      out_word,
    input  wire logic         out_ready
);

    // wclk side
    logic [`AFIFO_LANES-1:0] wr_inc;
    logic [`AFIFO_LANES-1:0] lane_full;
    tagged_word_t            wr_word;

    // rclk side
    logic [`AFIFO_LANES-1:0] rd_inc;
    logic [`AFIFO_LANES-1:0] lane_empty;
    tagged_word_t            rd_word [0:`AFIFO_LANES-1];

    // ----------------------------------------------------------------------
    // write steering
    // ----------------------------------------------------------------------
    lane_dispatch u_dispatch (
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .lane_full (lane_full),
        .wr_inc    (wr_inc),
        .wr_word   (wr_word)
    );

    // ----------------------------------------------------------------------
    // lanes, one async FIFO each
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < `AFIFO_LANES; i++) begin : g_lane
        afifo_lane u_lane (
            .wclk     (wclk),
            .rclk     (rclk),
            .aempty_n (aempty_n),
            .winc     (wr_inc[i]),
            .wdata    (wr_word),
            .wfull    (lane_full[i]),
            .rinc     (rd_inc[i]),
            .rdata    (rd_word[i]),
            .rempty   (lane_empty[i])
        );
    end

    // read merge into one stream
    lane_merge u_merge (
        .rclk       (rclk),
        .aempty_n   (aempty_n),
        .lane_empty (lane_empty),
        .rd_word    (rd_word),
        .rd_inc     (rd_inc),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* afifo_cfg.svh */
`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

`default_nettype none

// ----------------------------------------------------------------------
// bank sizing
// ----------------------------------------------------------------------

// payload bits carried next to the lane tag
`define AFIFO_DSIZE 8

// address bits per lane, depth is 2**AFIFO_ASIZE
// the comparator looks at the top two pointer bits, so keep this >= 2
`define AFIFO_ASIZE 4

// number of lanes in the bank, must be a power of two
// so the round-robin index wraps by itself
`define AFIFO_LANES 4

`default_nettype wire

`endif

/* afifo_cmp.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module afifo_cmp
    import afifo_pkg::*;
(
    input  wire logic aempty_n,
    input  wire ptr_t wptr,
    input  wire ptr_t rptr,
    output logic      near_empty_n,
    output logic      near_full_n
);

    localparam int N = `AFIFO_ASIZE - 1;

    logic dir_set;
    logic dir_clr;
    logic direction;

    // ----------------------------------------------------------------------
    // quadrant compare on the top two gray bits
    // ----------------------------------------------------------------------

    // write pointer one quadrant behind read pointer, heading for full
    assign dir_set = (wptr[N] ^ rptr[N-1]) & ~(wptr[N-1] ^ rptr[N]);

    // write pointer one quadrant ahead of read pointer, heading for empty
    assign dir_clr = ~(wptr[N] ^ rptr[N-1]) & (wptr[N-1] ^ rptr[N]);

    // set/clear latch, clear wins and reset forces the empty direction
    always_latch begin
        if (!aempty_n || dir_clr) begin
            direction <= 1'b0;
        end else if (dir_set) begin
            direction <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // flags, active low, raw and unsynchronized
    // ----------------------------------------------------------------------

    // equal pointers mean empty unless the writer caught up from behind
    assign near_empty_n = ~((wptr == rptr) && !direction);
    assign near_full_n  = ~((wptr == rptr) && direction);

endmodule

`default_nettype wire

/* afifo_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_lane
    import afifo_pkg::*;
(
    input  wire logic         wclk,
    input  wire logic         rclk,
    input  wire logic         aempty_n,
    input  wire logic         winc,
    input  wire tagged_word_t wdata,
    output logic              wfull,
    input  wire logic         rinc,
    output tagged_word_t      rdata,
    output logic              rempty
);

    ptr_t wptr;
    ptr_t rptr;
    logic near_empty_n;
    logic near_full_n;

    // ----------------------------------------------------------------------
    // storage, written on wclk and read at the gray read pointer
    // ----------------------------------------------------------------------
    afifo_mem u_mem (
        .wclk  (wclk),
        .wr_en (winc),
        .waddr (wptr),
        .raddr (rptr),
        .wdata (wdata),
        .rdata (rdata)
    );

    // ----------------------------------------------------------------------
    // cross-domain compare of the two gray pointers
    // ----------------------------------------------------------------------
    afifo_cmp u_cmp (
        .aempty_n     (aempty_n),
        .wptr         (wptr),
        .rptr         (rptr),
        .near_empty_n (near_empty_n),
        .near_full_n  (near_full_n)
    );

    // write side pointer, full in wclk domain
    afifo_wptr_full u_wptr_full (
        .wclk        (wclk),
        .aempty_n    (aempty_n),
        .winc        (winc),
        .near_full_n (near_full_n),
        .wptr        (wptr),
        .wfull       (wfull)
    );

    // read side pointer, empty in rclk domain
    afifo_rptr_empty u_rptr_empty (
        .rclk         (rclk),
        .aempty_n     (aempty_n),
        .rinc         (rinc),
        .near_empty_n (near_empty_n),
        .rptr         (rptr),
        .rempty       (rempty)
    );

endmodule

`default_nettype wire

/* afifo_mem.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module afifo_mem
    import afifo_pkg::*;
(
    input  wire logic         wclk,
    input  wire logic         wr_en,
    input  wire ptr_t         waddr,
    input  wire ptr_t         raddr,
    input  wire tagged_word_t wdata,
    output tagged_word_t      rdata
);

    localparam int DEPTH = 1 << `AFIFO_ASIZE;

    // storage, no reset on the payload
    tagged_word_t mem [0:DEPTH-1];

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------

    // gray address still hits every slot once per lap
    always_ff @(posedge wclk) begin
        if (wr_en) begin
            mem[waddr] <= wdata;
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------

    // asynchronous read, the word at the read pointer is always visible
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* afifo_pkg.sv */
`include "afifo_cfg.svh"

`default_nettype none

package afifo_pkg;

    // ----------------------------------------------------------------------
    // lane numbering
    // ----------------------------------------------------------------------

    // never let the tag collapse to zero bits
    localparam int LANE_BITS = (`AFIFO_LANES > 1) ? $clog2(`AFIFO_LANES) : 1;

    typedef logic [LANE_BITS-1:0] lane_idx_t;

    // ----------------------------------------------------------------------
    // per-lane pointers
    // ----------------------------------------------------------------------

    // gray coded, also used directly as the memory address
    typedef logic [`AFIFO_ASIZE-1:0] ptr_t;

    // ----------------------------------------------------------------------
    // payload
    // ----------------------------------------------------------------------

    // tag in the upper bits, data below
    typedef struct packed {
        lane_idx_t                lane;
        logic [`AFIFO_DSIZE-1:0] data;
    } tagged_word_t;

endpackage

`default_nettype wire

/* afifo_rptr_empty.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module afifo_rptr_empty
    import afifo_pkg::*;
(
    input  wire logic rclk,
    input  wire logic aempty_n,
    input  wire logic rinc,
    input  wire logic near_empty_n,
    output ptr_t      rptr,
    output logic      rempty
);

    logic [`AFIFO_ASIZE-1:0] rbin;
    logic [`AFIFO_ASIZE-1:0] rbin_next;
    ptr_t                    rgray_next;
    logic                    rempty2;

    // ----------------------------------------------------------------------
    // binary count and gray image
    // ----------------------------------------------------------------------

    // rinc comes pre-qualified from the merger
    assign rbin_next  = rbin + `AFIFO_ASIZE'(rinc);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge rclk or negedge aempty_n) begin
        if (!aempty_n) begin
            rbin <= '0;
            rptr <= '0;
        end else begin
            rbin <= rbin_next;
            rptr <= rgray_next;
        end
    end

    // ----------------------------------------------------------------------
    // empty flag
    // ----------------------------------------------------------------------

    // reset and the comparator both force empty, release takes two rclk edges
    always_ff @(posedge rclk or negedge aempty_n or negedge near_empty_n) begin
        if (!aempty_n || !near_empty_n) begin
            {rempty, rempty2} <= 2'b11;
        end else begin
            {rempty, rempty2} <= {rempty2, ~near_empty_n};
        end
    end

    // the merger must not pop a lane it sees as empty
    a_no_read_when_empty: assert property (
        @(posedge rclk) disable iff (!aempty_n)
        rinc |-> !rempty
    );

endmodule

`default_nettype wire

/* afifo_wptr_full.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module afifo_wptr_full
    import afifo_pkg::*;
(
    input  wire logic wclk,
    input  wire logic aempty_n,
    input  wire logic winc,
    input  wire logic near_full_n,
    output ptr_t      wptr,
    output logic      wfull
);

    logic [`AFIFO_ASIZE-1:0] wbin;
    logic [`AFIFO_ASIZE-1:0] wbin_next;
    ptr_t                    wgray_next;
    logic                    wfull2;

    // ----------------------------------------------------------------------
    // binary count and gray image
    // ----------------------------------------------------------------------

    // winc is already gated by the dispatcher
    assign wbin_next  = wbin + `AFIFO_ASIZE'(winc);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge wclk or negedge aempty_n) begin
        if (!aempty_n) begin
            wbin <= '0;
            wptr <= '0;
        end else begin
            wbin <= wbin_next;
            wptr <= wgray_next;
        end
    end

    // ----------------------------------------------------------------------
    // full flag
    // ----------------------------------------------------------------------

    // set at once by the comparator, released after two wclk edges
    always_ff @(posedge wclk or negedge aempty_n or negedge near_full_n) begin
        if (!aempty_n) begin
            {wfull, wfull2} <= 2'b00;
        end else if (!near_full_n) begin
            {wfull, wfull2} <= 2'b11;
        end else begin
            {wfull, wfull2} <= {wfull2, ~near_full_n};
        end
    end

    // the steering logic upstream has to honour full
    a_no_write_when_full: assert property (
        @(posedge wclk) disable iff (!aempty_n)
        winc |-> !wfull
    );

endmodule

`default_nettype wire

/* lane_dispatch.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module lane_dispatch
    import afifo_pkg::*;
(
    input  wire logic                    in_valid,
    input  wire tagged_word_t            in_word,
    output logic                         in_ready,
    input  wire logic [`AFIFO_LANES-1:0] lane_full,
    output logic [`AFIFO_LANES-1:0]      wr_inc,
    output tagged_word_t                 wr_word
);

    logic target_full;

    // ----------------------------------------------------------------------
    // lane select, purely combinational
    // ----------------------------------------------------------------------

    // full flag of the lane the tag points at
    assign target_full = lane_full[in_word.lane];

    // only the addressed lane blocks, the others stay open
    assign in_ready = ~target_full;

    // one-hot write strobe, gated by valid and by that lane's full
    always_comb begin
        wr_inc                = '0;
        wr_inc[in_word.lane] = in_valid & ~target_full;
    end

    // ----------------------------------------------------------------------
    // shared write bus
    // ----------------------------------------------------------------------

    // every lane sees the word, only the strobed one stores it
    // the tag stays in the stored word so the read side can check it
    assign wr_word = in_word;

endmodule

`default_nettype wire

/* lane_merge.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module lane_merge
    import afifo_pkg::*;
(
    input  wire logic                    rclk,
    input  wire logic                    aempty_n,
    input  wire logic [`AFIFO_LANES-1:0] lane_empty,
    input  wire tagged_word_t            rd_word [0:`AFIFO_LANES-1],
    output logic [`AFIFO_LANES-1:0]      rd_inc,
    output logic                         out_valid,
    output tagged_word_t                 out_word,
    input  wire logic                    out_ready
);

    lane_idx_t rr_ptr;
    lane_idx_t sel;
    logic      found;

    // ----------------------------------------------------------------------
    // cyclic search from the round-robin pointer
    // ----------------------------------------------------------------------

    // first non-empty lane at or after rr_ptr, the index wraps on its own
    always_comb begin
        lane_idx_t idx;
        sel   = rr_ptr;
        found = 1'b0;
        for (int k = 0; k < `AFIFO_LANES; k++) begin
            idx = rr_ptr + lane_idx_t'(k);
            if (!found && !lane_empty[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign out_valid = found;
    assign out_word  = rd_word[sel];

    // pop only the served lane, and only on a real handshake
    always_comb begin
        rd_inc      = '0;
        rd_inc[sel] = found & out_ready;
    end

    // ----------------------------------------------------------------------
    // round-robin pointer
    // ----------------------------------------------------------------------

    // move past the served lane on delivery
    // on a stall park on the presented lane so the word holds
    always_ff @(posedge rclk or negedge aempty_n) begin
        if (!aempty_n) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= out_ready ? lane_idx_t'(sel + 1'b1) : sel;
        end
    end

    // the tag written on the far side must match the lane it came out of
    a_tag_matches_lane: assert property (
        @(posedge rclk) disable iff (!aempty_n)
        out_valid |-> (out_word.lane == sel)
    );

    // a stalled word stays put until it is taken
    a_stall_holds_word: assert property (
        @(posedge rclk) disable iff (!aempty_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word))
    );

endmodule

`default_nettype wire

/* tb_afifo_bank.sv */
`include "afifo_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_afifo_bank
    import afifo_pkg::*;
();

    localparam int          LANES          = `AFIFO_LANES;
    localparam int          DEPTH          = 1 << `AFIFO_ASIZE;
    localparam int          WR_CYCLES      = 600;
    localparam int          TIMEOUT_CYCLES = WR_CYCLES + 2 * LANES * DEPTH * 4;
    // a lane queued this long has surely passed the two-flop empty release
    localparam int          MATURE         = 3;
    localparam logic [31:0] SEED           = 32'h8999ef88;

    logic         wclk = 1'b0;
    logic         rclk = 1'b0;
    logic         aempty_n;
    logic         in_valid;
    tagged_word_t in_word;
    logic         in_ready;
    logic         out_valid;
    tagged_word_t out_word;
    logic         out_ready;

    // one LFSR per clock domain, both from the same seed
    logic [31:0] wr_lfsr;
    logic [31:0] rd_lfsr;

    // per-lane model, ring buffers with the wclk time of each push
    tagged_word_t mq_word  [0:LANES-1][0:DEPTH-1];
    time          mq_time  [0:LANES-1][0:DEPTH-1];
    int           mq_head  [0:LANES-1];
    int           mq_count [0:LANES-1];
    time          last_pop [0:LANES-1];
    // rclk edges a lane has been non-empty in the model
    int           age      [0:LANES-1];

    int  rd_cycle;
    logic prev_ok;
    int  prev_lane;
    int  prev_cycle;

    int err_reset;
    int err_data;
    int err_flow;
    int err_order;

    always #10 wclk = ~wclk;
    always #14 rclk = ~rclk;

    afifo_bank dut (
        .wclk      (wclk),
        .rclk      (rclk),
        .aempty_n  (aempty_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready)
    );

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit, newest bit lands in the lsb
    task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // entry written before this time step, so the DUT may show it
    function automatic logic has_old(input int l);
        return (mq_count[l] > 0) && (mq_time[l][mq_head[l]] < $time);
    endfunction

    function automatic logic any_old();
        logic found;
        found = 1'b0;
        for (int j = 0; j < LANES; j++) begin
            found = found | has_old(j);
        end
        return found;
    endfunction

    function automatic int total_queued();
        int sum;
        sum = 0;
        for (int j = 0; j < LANES; j++) begin
            sum = sum + mq_count[j];
        end
        return sum;
    endfunction

    function automatic int total_errors();
        return err_reset + err_data + err_flow + err_order;
    endfunction

    task automatic report_counts();
        $display("error counts: reset %0d, data %0d, flow %0d, order %0d",
                 err_reset, err_data, err_flow, err_order);
    endtask

    task automatic check_idle(input string when_txt);
        if (out_valid !== 1'b0) begin
            err_reset++;
            $display("ERROR at %0t: out_valid is %b %s", $time, out_valid, when_txt);
        end
        if (in_ready !== 1'b1) begin
            err_reset++;
            $display("ERROR at %0t: in_ready is %b %s", $time, in_ready, when_txt);
        end
    endtask

    // new random word only once the port is free, a waiting word holds
    task automatic drive_write();
        logic [31:0]  bits;
        tagged_word_t w;
        if (!in_valid || in_ready) begin
            take_bits(wr_lfsr, 1, bits);
            in_valid <= bits[0];
            take_bits(wr_lfsr, LANE_BITS, bits);
            w.lane = lane_idx_t'(bits);
            take_bits(wr_lfsr, `AFIFO_DSIZE, bits);
            w.data = bits[`AFIFO_DSIZE-1:0];
            in_word <= w;
        end
    endtask

    // ----------------------------------------------------------------------
    // write side monitor, model push and overflow check
    // ----------------------------------------------------------------------
    always @(posedge wclk) begin
        int l;
        int held;
        int slot;
        if (aempty_n) begin
            l = in_word.lane;
            // a pop at this same edge is not yet seen by the DUT
            held = mq_count[l] + ((last_pop[l] == $time) ? 1 : 0);
            if (held >= DEPTH && in_ready) begin
                err_flow++;
                $display("ERROR at %0t: lane %0d holds %0d words but in_ready is high",
                         $time, l, held);
            end else if (in_valid && in_ready) begin
                slot              = (mq_head[l] + mq_count[l]) % DEPTH;
                mq_word[l][slot]  = in_word;
                mq_time[l][slot]  = $time;
                mq_count[l]       = mq_count[l] + 1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // read side monitor, data, order and underflow checks
    // ----------------------------------------------------------------------
    always @(posedge rclk) begin
        int           l;
        int           idx;
        logic         hit;
        logic [31:0]  bits;
        tagged_word_t exp;
        rd_cycle++;
        if (aempty_n) begin
            if (out_valid && !any_old()) begin
                err_flow++;
                $display("ERROR at %0t: out_valid high with every model queue empty", $time);
            end
            if (out_valid && out_ready) begin
                l = out_word.lane;
                if (!has_old(l)) begin
                    err_data++;
                    $display("ERROR at %0t: word %h delivered for empty lane %0d",
                             $time, out_word, l);
                end else begin
                    exp = mq_word[l][mq_head[l]];
                    if (out_word !== exp) begin
                        err_data++;
                        $display("ERROR at %0t: lane %0d got %h expected %h",
                                 $time, l, out_word, exp);
                    end
                    // back to back delivery, the pointer sits one past prev_lane
                    if (prev_ok && prev_cycle == rd_cycle - 1) begin
                        hit = 1'b0;
                        for (int k = 1; k <= LANES; k++) begin
                            idx = (prev_lane + k) % LANES;
                            if (!hit) begin
                                if (idx == l) begin
                                    hit = 1'b1;
                                end else if (age[idx] > MATURE) begin
                                    hit = 1'b1;
                                    err_order++;
                                    $display("ERROR at %0t: lane %0d served, lane %0d due after %0d",
                                             $time, l, idx, prev_lane);
                                end
                            end
                        end
                    end
                    mq_head[l]  = (mq_head[l] + 1) % DEPTH;
                    mq_count[l] = mq_count[l] - 1;
                    last_pop[l] = $time;
                end
                prev_ok    = 1'b1;
                prev_lane  = l;
                prev_cycle = rd_cycle;
            end
            for (int j = 0; j < LANES; j++) begin
                if (has_old(j)) begin
                    age[j] = age[j] + 1;
                end else begin
                    age[j] = 0;
                end
            end
            take_bits(rd_lfsr, 1, bits);
            out_ready <= bits[0];
        end
        if (rd_cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: %0d words still queued after %0d read clock cycles",
                     total_queued(), rd_cycle);
            report_counts();
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        wr_lfsr    = SEED;
        rd_lfsr    = SEED;
        rd_cycle   = 0;
        prev_ok    = 1'b0;
        prev_lane  = 0;
        prev_cycle = 0;
        err_reset  = 0;
        err_data   = 0;
        err_flow   = 0;
        err_order  = 0;
        for (int j = 0; j < LANES; j++) begin
            mq_head[j]  = 0;
            mq_count[j] = 0;
            last_pop[j] = 0;
            age[j]      = 0;
        end
        aempty_n  = 1'b1;
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b0;

        // reset falls just after time zero so every async clear sees the edge
        #1;
        aempty_n = 1'b0;
        repeat (5) begin
            @(posedge wclk);
            check_idle("during reset");
        end
        aempty_n <= 1'b1;
        @(posedge wclk);
        check_idle("on the first cycle after reset");

        // random traffic on both ports
        for (int c = 0; c < WR_CYCLES; c++) begin
            @(posedge wclk);
            drive_write();
        end

        // the last word may still wait for room in its lane
        @(posedge wclk);
        while (in_valid && !in_ready) begin
            @(posedge wclk);
        end
        in_valid <= 1'b0;

        // one more edge so the last accepted word is in the model
        @(posedge wclk);

        // drain, the timeout catches a lane that never empties
        while (total_queued() != 0) begin
            @(posedge rclk);
        end
        repeat (10) begin
            @(posedge rclk);
            if (out_valid !== 1'b0) begin
                err_flow++;
                $display("ERROR at %0t: out_valid is %b after the drain", $time, out_valid);
            end
        end

        report_counts();
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
